/* src/alu_pkg.sv */
// unsigned fixed-point only; one-hot opcodes without the sqrt code, mode meaning depends on opcode
package alu_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int OPND_WIDTH = 13;  // x, y and result
    localparam int MULR_WIDTH = 8;   // multiplier bits taken from y
    localparam int QUOT_WIDTH = 9;   // widest quotient (T27 / T36)

    ////////////////////////////////////////
    // opcodes and modes
    ////////////////////////////////////////

    // one-hot as seen by the datapath top
    typedef enum logic [3:0] {
        ALU_MULTIPLY = 4'b1000,
        ALU_DIVISION = 4'b0100,
        ALU_UNKNOWN  = 4'b0001
    } alu_op_e;

    // multiply modes
    typedef enum logic [1:0] {
        MULTI_PURE = 2'd0,  // x * pure fraction
        MULTI_FRAC = 2'd1,  // x * (1 + fraction)
        MULTI_MAXM = 2'd2   // bounded to x * 2
    } mul_mode_e;

    // divide modes
    typedef enum logic [1:0] {
        SA_DIV = 2'd0,  // annealing ratio x*256/y
        CF_T27 = 2'd1,  // curve fit step x*128/y
        CF_T36 = 2'd2   // curve fit step x*64/y
    } div_mode_e;

    ////////////////////////////////////////
    // request word
    ////////////////////////////////////////

    // 32 bits total
    typedef struct packed {
        alu_op_e               op;
        logic [1:0]            mode;  // mul_mode_e or div_mode_e by op
        logic [OPND_WIDTH-1:0] x;     // multiplicand or dividend
        logic [OPND_WIDTH-1:0] y;     // multiplier (low 8 bits) or divisor
    } alu_req_t;

    // the mode field is read through a cast in the engines
    // e.g. mul_mode_e'(req.mode) or div_mode_e'(req.mode)
    // code 3 is not a defined mode in either set
    // multiply treats it as pure and divide as SA_DIV

endpackage

/* src/alu_ctrl.sv */
// start must stay high with req stable until done; an unknown opcode waits forever for start to drop
module alu_ctrl (
    input  logic                            CLK,
    input  logic                            RST_N,
    input  logic                            start,
    input  alu_pkg::alu_req_t               req,
    output alu_pkg::alu_req_t               opnd,
    output logic                            mul_go,
    output logic                            div_go,
    input  logic                            mul_fin,
    input  logic [alu_pkg::OPND_WIDTH-1:0]  mul_value,
    input  logic                            div_fin,
    input  logic [alu_pkg::OPND_WIDTH-1:0]  div_value,
    output logic [alu_pkg::OPND_WIDTH-1:0]  result,
    output logic                            done
);
    import alu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,      // waiting for start
        LAUNCH,    // go pulse is out
        WAIT_MUL,  // multiplier running
        WAIT_DIV,  // divider running
        HOLD,      // result valid until start drops
        STALL      // unknown opcode parked here
    } ctrl_state_e;

    ctrl_state_e state;

    logic take_req;  // accept edge
    assign take_req = start && (state == IDLE);

    ////////////////////////////////////////
    // request latch
    ////////////////////////////////////////

    // engines sample opnd only on their go pulse
    always_ff @(posedge CLK) begin
        if (take_req) begin
            opnd <= req;
        end
    end

    ////////////////////////////////////////
    // handshake FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state  <= IDLE;
            mul_go <= 1'b0;
            div_go <= 1'b0;
            result <= '0;
        end else begin
            mul_go <= 1'b0;  // single cycle pulses
            div_go <= 1'b0;
            if (!start) begin
                // abort or normal release
                state  <= IDLE;
                result <= '0;
            end else begin
                case (state)
                    IDLE: begin
                        mul_go <= (req.op == ALU_MULTIPLY);
                        div_go <= (req.op == ALU_DIVISION);
                        state  <= LAUNCH;
                    end
                    LAUNCH: begin
                        case (opnd.op)
                            ALU_MULTIPLY: state <= WAIT_MUL;
                            ALU_DIVISION: state <= WAIT_DIV;
                            ALU_UNKNOWN:  state <= STALL;
                            default:      state <= STALL;  // sqrt code and garbage too
                        endcase
                    end
                    WAIT_MUL: begin
                        if (mul_fin) begin
                            result <= mul_value;
                            state  <= HOLD;
                        end
                    end
                    WAIT_DIV: begin
                        if (div_fin) begin
                            result <= div_value;
                            state  <= HOLD;
                        end
                    end
                    HOLD:    state <= HOLD;   // until start falls
                    STALL:   state <= STALL;  // never completes
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // stray fin from an aborted run is dropped by the wait states above
    assign done = (state == HOLD);

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // done only ever answers a held start
    a_done_needs_start: assert property (
        @(posedge CLK) disable iff (!RST_N)
        done |-> $past(start)
    );

    // one engine per request
    a_single_go: assert property (
        @(posedge CLK) disable iff (!RST_N)
        !(mul_go && div_go)
    );

endmodule

/* src/shift_add_mul.sv */
// unsigned x (13 bits) times y[7:0]; FRAC_BITS must not exceed MULR_WIDTH, result truncated to 13 bits
module shift_add_mul #(
    parameter int FRAC_BITS = 8
) (
    input  logic                            CLK,
    input  logic                            RST_N,
    input  logic                            go,
    input  alu_pkg::alu_req_t               opnd,
    output logic                            fin,
    output logic [alu_pkg::OPND_WIDTH-1:0]  value
);
    import alu_pkg::*;

    localparam int ACC_WIDTH = OPND_WIDTH + MULR_WIDTH;  // full product, no truncation
    localparam int CNT_WIDTH = $clog2(MULR_WIDTH + 1);

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_ADD,    // one multiplier bit per cycle
        MS_SCALE   // drop fraction bits and add x
    } mul_state_e;

    mul_state_e            state;
    logic [CNT_WIDTH-1:0]  cnt;     // weight of current multiplier bit
    logic [ACC_WIDTH-1:0]  acc;
    logic [MULR_WIDTH-1:0] mulr;    // shifts right, bit 0 is next
    logic [OPND_WIDTH-1:0] x_q;
    logic                  frac_q;  // add x after scaling
    logic                  go_frac;
    logic                  go_maxm;
    logic [ACC_WIDTH-1:0]  x_ext;
    logic [ACC_WIDTH-1:0]  part;
    logic [ACC_WIDTH-1:0]  scaled;

    // mode decode at go
    always_comb begin
        go_frac = 1'b0;
        go_maxm = 1'b0;
        case (mul_mode_e'(opnd.mode))
            MULTI_PURE: go_frac = 1'b0;
            MULTI_FRAC: go_frac = 1'b1;
            MULTI_MAXM: go_maxm = 1'b1;
            default:    go_frac = 1'b0;  // code 3 runs as pure
        endcase
    end

    assign x_ext  = ACC_WIDTH'(x_q);
    assign part   = mulr[0] ? (x_ext << cnt) : '0;  // shifted x when bit set
    assign scaled = (acc >> FRAC_BITS) + (frac_q ? x_ext : '0);

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state <= MS_IDLE;
            cnt   <= '0;
            fin   <= 1'b0;
        end else begin
            fin <= 1'b0;
            if (go) begin
                cnt   <= CNT_WIDTH'(1);  // bit 0 folded into the load
                state <= go_maxm ? MS_IDLE : MS_ADD;
                fin   <= go_maxm;        // x2 is done at once
            end else if (state == MS_ADD) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_WIDTH'(MULR_WIDTH - 1)) begin
                    state <= MS_SCALE;
                end
            end else if (state == MS_SCALE) begin
                fin   <= 1'b1;
                state <= MS_IDLE;
            end
        end
    end

    // datapath
    always_ff @(posedge CLK) begin
        if (go) begin
            x_q    <= opnd.x;
            frac_q <= go_frac;
            acc    <= opnd.y[0] ? ACC_WIDTH'(opnd.x) : '0;
            mulr   <= opnd.y[MULR_WIDTH-1:0] >> 1;
            if (go_maxm) begin
                value <= {opnd.x[OPND_WIDTH-2:0], 1'b0};  // 2x, top bit lost
            end
        end else if (state == MS_ADD) begin
            acc  <= acc + part;
            mulr <= mulr >> 1;
        end else if (state == MS_SCALE) begin
            value <= scaled[OPND_WIDTH-1:0];
        end
    end

    // fin is tied to the latest go by fixed latency
    a_fin_after_go: assert property (
        @(posedge CLK) disable iff (!RST_N)
        fin |-> $past(go) || $past(go, MULR_WIDTH + 1)
    );

endmodule

/* src/restoring_div.sv */
// SA_DIV is exact only for x < y (y = 0 gives 511); T27/T36 saturate when x/4 >= y
module restoring_div (
    input  logic                            CLK,
    input  logic                            RST_N,
    input  logic                            go,
    input  alu_pkg::alu_req_t               opnd,
    output logic                            fin,
    output logic [alu_pkg::OPND_WIDTH-1:0]  value
);
    import alu_pkg::*;

    localparam int REM_WIDTH = OPND_WIDTH + 1;  // holds up to 2y after a shift
    localparam int DVD_WIDTH = OPND_WIDTH + QUOT_WIDTH;
    localparam int CNT_WIDTH = $clog2(QUOT_WIDTH + 1);
    localparam logic [QUOT_WIDTH-1:0] SAT_MAX = '1;                       // 511
    localparam logic [QUOT_WIDTH-1:0] SAT_T36 = QUOT_WIDTH'(1) << (QUOT_WIDTH - 1);  // 256

    typedef enum logic [1:0] {
        DV_IDLE,
        DV_SHIFT,  // bring in next dividend bit
        DV_TRIAL   // subtract y if it fits
    } div_state_e;

    div_state_e            state;
    logic [CNT_WIDTH-1:0]  cnt;    // quotient bits done
    logic [CNT_WIDTH-1:0]  nbits;  // 8 for SA, 9 otherwise
    logic [REM_WIDTH-1:0]  rem;    // partial remainder
    logic [QUOT_WIDTH-1:0] low;    // dividend bits not yet shifted in
    logic [QUOT_WIDTH-1:0] quot;
    logic [OPND_WIDTH-1:0] y_q;

    logic                  go_sat;
    logic [QUOT_WIDTH-1:0] sat_val;
    logic [DVD_WIDTH-1:0]  dvd;    // x aligned per mode
    logic [CNT_WIDTH-1:0]  nbits_init;
    logic                  ge;
    logic                  last_bit;
    logic [QUOT_WIDTH-1:0] quot_next;

    ////////////////////////////////////////
    // load decode
    ////////////////////////////////////////

    always_comb begin
        go_sat     = 1'b0;
        sat_val    = SAT_MAX;
        dvd        = {opnd.x, {QUOT_WIDTH{1'b0}}};
        nbits_init = CNT_WIDTH'(QUOT_WIDTH);
        case (div_mode_e'(opnd.mode))
            CF_T27: begin
                go_sat = (opnd.x >> 2) >= opnd.y;
                dvd    = {opnd.x, {QUOT_WIDTH{1'b0}}} >> 2;  // x*128 over 9 bits
            end
            CF_T36: begin
                go_sat  = (opnd.x >> 2) >= opnd.y;
                sat_val = SAT_T36;
                dvd     = {opnd.x, {QUOT_WIDTH{1'b0}}} >> 3;  // x*64 over 9 bits
            end
            default: begin  // SA_DIV and code 3
                go_sat     = (opnd.y == '0);
                nbits_init = CNT_WIDTH'(QUOT_WIDTH - 1);     // x*256 over 8 bits
            end
        endcase
    end

    assign ge        = rem >= REM_WIDTH'(y_q);
    assign quot_next = {quot[QUOT_WIDTH-2:0], ge};
    assign last_bit  = (cnt == nbits - 1'b1);

    ////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state <= DV_IDLE;
            cnt   <= '0;
            fin   <= 1'b0;
        end else begin
            fin <= 1'b0;
            if (go) begin
                cnt   <= '0;
                state <= go_sat ? DV_IDLE : DV_SHIFT;
                fin   <= go_sat;  // saturation answers next cycle
            end else if (state == DV_SHIFT) begin
                state <= DV_TRIAL;
            end else if (state == DV_TRIAL) begin
                cnt   <= cnt + 1'b1;
                state <= last_bit ? DV_IDLE : DV_SHIFT;
                fin   <= last_bit;
            end
        end
    end

    // datapath
    always_ff @(posedge CLK) begin
        if (go) begin
            y_q   <= opnd.y;
            rem   <= REM_WIDTH'(dvd[DVD_WIDTH-1:QUOT_WIDTH]);  // below y when not saturated
            low   <= dvd[QUOT_WIDTH-1:0];
            quot  <= '0;
            nbits <= nbits_init;
            if (go_sat) begin
                value <= OPND_WIDTH'(sat_val);
            end
        end else if (state == DV_SHIFT) begin
            rem <= {rem[REM_WIDTH-2:0], low[QUOT_WIDTH-1]};
            low <= {low[QUOT_WIDTH-2:0], 1'b0};
        end else if (state == DV_TRIAL) begin
            if (ge) begin
                rem <= rem - REM_WIDTH'(y_q);
            end
            quot <= quot_next;
            if (last_bit) begin
                value <= OPND_WIDTH'(quot_next);
            end
        end
    end

    a_cnt_bound: assert property (
        @(posedge CLK) disable iff (!RST_N)
        cnt <= CNT_WIDTH'(QUOT_WIDTH)
    );

endmodule

/* src/share_alu.sv */
// one operation at a time through start/done; FRAC_BITS must not exceed MULR_WIDTH
module share_alu #(
    parameter int FRAC_BITS = 8  // multiply fraction point
) (
    input  logic                            CLK,
    input  logic                            RST_N,
    input  logic                            start,
    input  alu_pkg::alu_req_t               req,
    output logic [alu_pkg::OPND_WIDTH-1:0]  result,
    output logic                            done
);
    import alu_pkg::*;

    alu_req_t              opnd;       // latched request to both engines
    logic                  mul_go;
    logic                  div_go;
    logic                  mul_fin;
    logic                  div_fin;
    logic [OPND_WIDTH-1:0] mul_value;
    logic [OPND_WIDTH-1:0] div_value;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    alu_ctrl alu_ctrl_inst (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .start     (start),
        .req       (req),
        .opnd      (opnd),
        .mul_go    (mul_go),
        .div_go    (div_go),
        .mul_fin   (mul_fin),
        .mul_value (mul_value),
        .div_fin   (div_fin),
        .div_value (div_value),
        .result    (result),
        .done      (done)
    );

    ////////////////////////////////////////
    // engines
    ////////////////////////////////////////

    shift_add_mul #(
        .FRAC_BITS (FRAC_BITS)
    ) shift_add_mul_inst (
        .CLK   (CLK),
        .RST_N (RST_N),
        .go    (mul_go),
        .opnd  (opnd),
        .fin   (mul_fin),
        .value (mul_value)
    );

    restoring_div restoring_div_inst (
        .CLK   (CLK),
        .RST_N (RST_N),
        .go    (div_go),
        .opnd  (opnd),
        .fin   (div_fin),
        .value (div_value)
    );

endmodule

/* testbench/alu_checker.sv */
// expected results use the multiply rules for FRAC_BITS = 8; SA_DIV is defined only for x < y or y = 0
module alu_checker (
    input  logic                           CLK,
    input  logic                           RST_N,
    input  logic                           start,
    input  alu_pkg::alu_req_t              req,
    input  logic                           done,
    input  logic [alu_pkg::OPND_WIDTH-1:0] result,
    input  logic                           exp_valid,  // trace line carries a value
    input  logic [alu_pkg::OPND_WIDTH-1:0] exp_value
);
    import alu_pkg::*;

    int                    error_count = 0;
    int                    check_count = 0;
    logic                  prev_start;   // sampled one negedge back
    logic                  prev_done;
    logic [OPND_WIDTH-1:0] prev_result;

    ////////////////////////////////////////
    // reference arithmetic
    ////////////////////////////////////////

    // exact math on wide unsigned values then truncated
    function automatic logic [OPND_WIDTH-1:0] rule_value(input alu_req_t r);
        longint unsigned x;
        longint unsigned y;
        longint unsigned q;
        x = 64'(r.x);
        y = 64'(r.y);
        q = 64'd0;
        if (r.op == ALU_MULTIPLY) begin
            y = y % 64'd256;  // low 8 bits only
            case (mul_mode_e'(r.mode))
                MULTI_FRAC: q = (x * y) / 64'd256 + x;
                MULTI_MAXM: q = x * 64'd2;
                default:    q = (x * y) / 64'd256;
            endcase
        end else begin
            case (div_mode_e'(r.mode))
                CF_T27:  q = (x / 64'd4 >= y) ? 64'd511 : (x * 64'd128) / y;
                CF_T36:  q = (x / 64'd4 >= y) ? 64'd256 : (x * 64'd64) / y;
                default: q = (y == 64'd0) ? 64'd511 : (x * 64'd256) / y;
            endcase
        end
        return q[OPND_WIDTH-1:0];
    endfunction

    task automatic report(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        error_count++;
    endtask

    ////////////////////////////////////////
    // port watch sampled mid cycle
    ////////////////////////////////////////

    always @(negedge CLK) begin
        if (!RST_N) begin
            if (done) begin
                report("done high during reset");
            end
            prev_start  = 1'b0;
            prev_done   = 1'b0;
            prev_result = '0;
        end else begin
            if (done && !prev_start) begin
                report("done still high one cycle after start fell");
            end
            if (!done && prev_done && prev_start) begin
                report("done fell while start was still high");
            end
            if (done && !prev_done) begin
                check_count++;  // new completion
                if (req.op != ALU_MULTIPLY && req.op != ALU_DIVISION) begin
                    report($sformatf("done rose for unknown opcode %h", req.op));
                end else if (result != rule_value(req)) begin
                    report($sformatf("op %h mode %0d x %h y %h result %h expected %h",
                        req.op, req.mode, req.x, req.y, result, rule_value(req)));
                end
                if (exp_valid && result != exp_value) begin
                    report($sformatf("result %h differs from trace value %h",
                        result, exp_value));
                end
            end else if (done && result != prev_result) begin
                report($sformatf("result moved from %h to %h while done held",
                    prev_result, result));
            end
            prev_start  = start;
            prev_done   = done;
            prev_result = result;
        end
    end

endmodule

/* testbench/tb_share_alu.sv */
// trace path is relative to the project root; FRAC_BITS stays 8 to match the checker arithmetic
module tb_share_alu;
    import alu_pkg::*;

    localparam int DONE_LIMIT   = 60;  // slowest op is about 22 cycles
    localparam int HOLD_CYCLES  = 10;  // extra cycles with start held after done
    localparam int STALL_CYCLES = 40;  // unknown opcode watch window
    localparam int DROP_LIMIT   = 4;

    logic                  CLK;
    logic                  RST_N;
    logic                  start;
    alu_req_t              req;
    logic [OPND_WIDTH-1:0] result;
    logic                  done;
    logic                  exp_valid;
    logic [OPND_WIDTH-1:0] exp_value;
    logic [31:0]           rng_state;
    int                    run_errors;  // timeouts and file trouble
    int                    trace_ops;
    int                    total_errors;

    share_alu #(
        .FRAC_BITS (8)
    ) share_alu_inst (
        .CLK    (CLK),
        .RST_N  (RST_N),
        .start  (start),
        .req    (req),
        .result (result),
        .done   (done)
    );

    alu_checker alu_checker_inst (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .start     (start),
        .req       (req),
        .done      (done),
        .result    (result),
        .exp_valid (exp_valid),
        .exp_value (exp_value)
    );

    always #2 CLK = ~CLK;  // period 4

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle;
        @(posedge CLK);
        #1;  // inputs move just after the edge
    endtask

    // one full handshake, or an abort after a few cycles
    task automatic run_op(input alu_req_t r, input logic abort, input logic has_exp,
                          input logic [OPND_WIDTH-1:0] exp_in);
        int cycles;
        req       = r;
        exp_valid = has_exp && !abort;
        exp_value = exp_in;
        start     = 1'b1;
        cycles    = 0;
        if (abort) begin
            repeat (3) next_cycle();  // engine mid run
        end else if (r.op != ALU_MULTIPLY && r.op != ALU_DIVISION) begin
            repeat (STALL_CYCLES) next_cycle();  // any done is flagged by the checker
        end else begin
            while (!done && cycles < DONE_LIMIT) begin
                next_cycle();
                cycles++;
            end
            if (!done) begin
                $display("timeout at %0t: done never rose for op %h mode %0d x %h y %h",
                    $time, r.op, r.mode, r.x, r.y);
                run_errors++;
            end else begin
                repeat (HOLD_CYCLES) next_cycle();  // result must not move
            end
        end
        start  = 1'b0;
        cycles = 0;
        while (done && cycles < DROP_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (done) begin
            $display("timeout at %0t: done stayed high after start fell", $time);
            run_errors++;
        end
        next_cycle();  // start low for a whole cycle
    endtask

    // columns: op mode x y abort expected, all hex
    task automatic run_trace;
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_mode;
        logic [31:0] f_x;
        logic [31:0] f_y;
        logic [31:0] f_abort;
        logic [31:0] f_exp;
        alu_req_t    r;
        fd = $fopen("testbench/alu_trace.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open testbench/alu_trace.txt");
            run_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h",
                    f_op, f_mode, f_x, f_y, f_abort, f_exp);
                if (fields == 6) begin  // comment lines fail to parse
                    r.op   = alu_op_e'(f_op[3:0]);
                    r.mode = f_mode[1:0];
                    r.x    = f_x[OPND_WIDTH-1:0];
                    r.y    = f_y[OPND_WIDTH-1:0];
                    run_op(r, f_abort[0], 1'b1, f_exp[OPND_WIDTH-1:0]);
                    trace_ops++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_random_mul(input int count);
        alu_req_t r;
        for (int i = 0; i < count; i++) begin
            r.op      = ALU_MULTIPLY;
            rng_state = lcg_next(rng_state);
            r.mode    = 2'(rng_state[23:16] % 8'd3);  // modes 0..2
            rng_state = lcg_next(rng_state);
            r.x       = rng_state[28:16];
            rng_state = lcg_next(rng_state);
            r.y       = rng_state[28:16];  // upper bits ignored by multiply
            run_op(r, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic run_random_div(input int count);
        alu_req_t r;
        for (int i = 0; i < count; i++) begin
            r.op      = ALU_DIVISION;
            r.mode    = 2'(i % 3);
            rng_state = lcg_next(rng_state);
            r.y       = rng_state[28:16] | 13'd1;  // nonzero divisor
            rng_state = lcg_next(rng_state);
            if (r.mode == 2'd0) begin
                r.x = rng_state[28:16] % r.y;  // SA_DIV needs x < y
            end else begin
                r.x = rng_state[28:16];
            end
            run_op(r, 1'b0, 1'b0, '0);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        CLK        = 1'b0;
        RST_N      = 1'b0;
        start      = 1'b0;
        req        = '0;
        exp_valid  = 1'b0;
        exp_value  = '0;
        rng_state  = 32'hfbee;
        run_errors = 0;
        trace_ops  = 0;
        repeat (3) @(posedge CLK);
        #1;
        RST_N = 1'b1;
        next_cycle();  // done low after reset, seen by checker
        run_trace();
        if (trace_ops == 0) begin
            $display("error: no operations read from the trace");
            run_errors++;
        end
        run_random_mul(12);
        run_random_div(9);
        total_errors = alu_checker_inst.error_count + run_errors;
        $display("completions %0d, trace ops %0d, check errors %0d, other errors %0d",
            alu_checker_inst.check_count, trace_ops, alu_checker_inst.error_count,
            run_errors);
        if (total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/alu_trace.txt */
# columns: op mode x y abort expected, all hex
# op 8 multiply, 4 divide, 1 unknown; abort 1 drops start mid operation
# multiply pure
8 0 0100 0080 0 0080
8 0 1fff 00ff 0 1fdf
8 0 00c3 01a5 0 007d
# multiply fraction plus one
8 1 0100 0040 0 0140
8 1 1fff 00ff 0 1fde
8 1 00ab 0033 0 00cd
# multiply times two
8 2 00ab 0000 0 0156
8 2 1234 0055 0 0468
# annealing division, x < y and y = 0
4 0 0064 00c8 0 0080
4 0 0001 1fff 0 0000
4 0 03e7 03e8 0 00ff
4 0 0123 0000 0 01ff
# T27 normal and saturated
4 1 0010 000a 0 00cc
4 1 0064 001a 0 01ec
4 1 0028 000a 0 01ff
4 1 0000 0000 0 01ff
# T36 normal and saturated
4 2 000c 0007 0 006d
4 2 1fff 0800 0 00ff
4 2 0100 0040 0 0100
4 2 1fff 0001 0 0100
# abort then a fresh request
8 0 0100 00ff 1 0000
4 1 0010 000a 0 00cc
4 0 0064 00c8 1 0000
8 1 0100 0040 0 0140
# unknown opcode stalls
1 0 0123 0045 0 0000

/* share_alu.f */
src/alu_pkg.sv
src/alu_ctrl.sv
src/shift_add_mul.sv
src/restoring_div.sv
src/share_alu.sv
testbench/alu_checker.sv
testbench/tb_share_alu.sv

/* run.sh */
#!/bin/sh
# build the share_alu testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_share_alu \
    -f share_alu.f -o sim_share_alu

./obj_dir/sim_share_alu > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
